// ==== pit_defs.svh ====
// ==========================================================
// addresses assume a 2-bit port offset inside the PIT window
// ==========================================================
`ifndef PIT_DEFS_SVH
`define PIT_DEFS_SVH

// number of timer channels behind the bus controller
`define PIT_NUM_CH      2

// port offsets, the read-back command address is not decoded
`define PIT_ADDR_CH0    2'd0
`define PIT_ADDR_CH1    2'd1
`define PIT_ADDR_CTRL   2'd3

// control word fields
`define PIT_CW_SEL_MSB  7
`define PIT_CW_SEL_LSB  6
`define PIT_CW_RW_MSB   5
`define PIT_CW_RW_LSB   4
`define PIT_CW_MODE_MSB 3
`define PIT_CW_MODE_LSB 1

`endif

// ==== pit_pkg.sv ====
// ==========================================================
// binary counting only, there is no BCD count type
// ==========================================================
`default_nettype none

package pit_pkg;

    // one byte on the CPU data bus
    typedef logic [7:0] pit_byte_t;

    // counter, reload and latched count value
    typedef logic [15:0] pit_count_t;

    // access mode from the control word
    // 00 latch command, 01 low byte only, 10 high byte only,
    // 11 low byte then high byte
    typedef logic [1:0] pit_rw_t;

    // counting mode field, only the low two bits select behaviour here
    typedef logic [2:0] pit_mode_t;

    // which byte of a 16-bit value the next access goes to
    // shared by the reload write sequence and the count read sequence
    typedef enum logic {
        byte_low  = 1'b0,
        byte_high = 1'b1
    } pit_byte_sel_e;

endpackage

`default_nettype wire

// ==== pit_channel_if.sv ====
// ==========================================================
// strobes are single clk pulses with no handshake
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

interface pit_channel_if
    import pit_pkg::*;
();

    pit_byte_t reload_in;
    logic      load;
    pit_rw_t   rw_in;
    pit_mode_t mode_in;
    logic      configure;
    logic      latch_count;
    logic      read_count;
    pit_byte_t count_out;

    // bus controller side
    modport ctrl (
        output reload_in, load, rw_in, mode_in, configure, latch_count, read_count,
        input  count_out
    );

    // timer channel side
    modport timer (
        input  reload_in, load, rw_in, mode_in, configure, latch_count, read_count,
        output count_out
    );

endinterface

`default_nettype wire

// ==== pit_timer_unit.sv ====
// ==========================================================
// only rate generator (x10) and square wave (x11) count, other
// modes hold the count; pit_clk must be much slower than clk
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module pit_timer_unit
    import pit_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         pit_clk,
    input  logic         gate,
    output logic         out,
    pit_channel_if.timer bus
);

    logic          last_pit_clk;
    logic          last_gate;
    logic          pit_tick;
    logic          trigger;

    pit_mode_t     mode;
    pit_rw_t       rw;
    pit_count_t    reload;
    pit_byte_t     reload_low;
    pit_byte_sel_e load_ptr;

    pit_count_t    count;
    pit_count_t    count_next;
    pit_count_t    sq_reload;
    logic          out_next;

    pit_count_t    latched_count;
    logic          latched;
    logic          take_latch;
    pit_byte_sel_e read_ptr;
    pit_count_t    read_src;

    // one flop per input, the edge shows up one clk after the level changes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            last_pit_clk <= 1'b0;
            last_gate    <= 1'b0;
        end else begin
            last_pit_clk <= pit_clk;
            last_gate    <= gate;
        end
    end

    assign pit_tick = pit_clk & ~last_pit_clk;
    assign trigger  = gate & ~last_gate;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mode <= '0;
            rw   <= '0;
        end else if (bus.configure) begin
            mode <= bus.mode_in;
            rw   <= bus.rw_in;
        end
    end

    // a new control word discards any half written reload value
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reload   <= '0;
            load_ptr <= byte_low;
        end else if (bus.configure) begin
            reload   <= '0;
            load_ptr <= byte_low;
        end else if (bus.load) begin
            case (rw)
                2'b01: reload[7:0]  <= bus.reload_in;
                2'b10: reload[15:8] <= bus.reload_in;
                2'b11: begin
                    if (load_ptr == byte_high) begin
                        reload   <= {bus.reload_in, reload_low};
                        load_ptr <= byte_low;
                    end else begin
                        load_ptr <= byte_high;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (bus.load && rw == 2'b11 && load_ptr == byte_low)
            reload_low <= bus.reload_in;
    end

    // square wave counts by two, so an odd reload is rounded down
    assign sq_reload = {reload[15:1], 1'b0};

    always_comb begin
        count_next = count;
        out_next   = out;
        case (mode[1:0])
            2'b10: begin
                if (trigger)
                    count_next = reload - 16'd1;
                else if (pit_tick && gate)
                    count_next = (count == 16'd0) ? reload - 16'd1 : count - 16'd1;
                // out follows the count so the low pulse lines up with count 1
                out_next = (count_next != 16'd1);
            end
            2'b11: begin
                if (trigger) begin
                    count_next = sq_reload;
                    out_next   = 1'b1;
                end else if (pit_tick && gate) begin
                    if (count <= 16'd2) begin
                        count_next = sq_reload;
                        out_next   = ~out;
                    end else begin
                        count_next = count - 16'd2;
                    end
                end
            end
            default: ;
        endcase
        if (!gate)
            out_next = 1'b1;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
            out   <= 1'b1;
        end else begin
            count <= count_next;
            out   <= out_next;
        end
    end

    // a second latch command is ignored until the first value has been read
    assign take_latch = bus.latch_count && !latched;

    always_ff @(posedge clk) begin
        if (take_latch)
            latched_count <= count;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            latched  <= 1'b0;
            read_ptr <= byte_low;
        end else if (bus.configure) begin
            latched  <= 1'b0;
            read_ptr <= (bus.rw_in == 2'b10) ? byte_high : byte_low;
        end else if (take_latch) begin
            latched  <= 1'b1;
            read_ptr <= (rw == 2'b10) ? byte_high : byte_low;
        end else if (bus.read_count) begin
            if (rw == 2'b11 && read_ptr == byte_low) begin
                read_ptr <= byte_high;
            end else begin
                // last byte of the access has gone out
                latched  <= 1'b0;
                read_ptr <= (rw == 2'b10) ? byte_high : byte_low;
            end
        end
    end

    assign read_src      = latched ? latched_count : count;
    assign bus.count_out = (read_ptr == byte_high) ? read_src[15:8] : read_src[7:0];

    // the bus controller sends one command per channel per cycle
    a_load_cfg_excl: assert property (
        @(posedge clk) disable iff (reset) !(bus.load && bus.configure)
    ) else $error("load and configure asserted together");

    a_gate_low_out: assert property (
        @(posedge clk) disable iff (reset) !gate |=> out
    ) else $error("out not high after gate low");

endmodule

`default_nettype wire

// ==== pit_bus_ctrl.sv ====
// ==========================================================
// no read-back command, control words for channel 2 are dropped
// ==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "pit_defs.svh"

module pit_bus_ctrl
    import pit_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         cs,
    input  logic         wr_en,
    input  logic         rd_en,
    input  logic [1:0]   addr,
    input  pit_byte_t    wdata,
    output pit_byte_t    rdata,
    input  logic         out0,
    output logic         irq,
    pit_channel_if.ctrl  ch0,
    pit_channel_if.ctrl  ch1
);

    logic      wr;
    logic      rd;
    logic [1:0] cw_sel;
    pit_rw_t   cw_rw;
    pit_mode_t cw_mode;
    logic      cw_wr;
    logic      last_out0;
    logic      ch0_busy;
    logic      ch1_busy;

    assign wr      = cs & wr_en;
    assign rd      = cs & rd_en;
    assign cw_sel  = wdata[`PIT_CW_SEL_MSB:`PIT_CW_SEL_LSB];
    assign cw_rw   = wdata[`PIT_CW_RW_MSB:`PIT_CW_RW_LSB];
    assign cw_mode = wdata[`PIT_CW_MODE_MSB:`PIT_CW_MODE_LSB];

    // control word for a channel that exists
    assign cw_wr = wr && (addr == `PIT_ADDR_CTRL) && (cw_sel < `PIT_NUM_CH);

    always_comb begin
        ch0.reload_in   = wdata;
        ch0.rw_in       = cw_rw;
        ch0.mode_in     = cw_mode;
        ch0.load        = wr && (addr == `PIT_ADDR_CH0);
        ch0.configure   = cw_wr && (cw_sel == 2'd0) && (cw_rw != 2'b00);
        ch0.latch_count = cw_wr && (cw_sel == 2'd0) && (cw_rw == 2'b00);
        ch0.read_count  = rd && (addr == `PIT_ADDR_CH0);

        ch1.reload_in   = wdata;
        ch1.rw_in       = cw_rw;
        ch1.mode_in     = cw_mode;
        ch1.load        = wr && (addr == `PIT_ADDR_CH1);
        ch1.configure   = cw_wr && (cw_sel == 2'd1) && (cw_rw != 2'b00);
        ch1.latch_count = cw_wr && (cw_sel == 2'd1) && (cw_rw == 2'b00);
        ch1.read_count  = rd && (addr == `PIT_ADDR_CH1);
    end

    // the byte is taken at the same edge that advances the channel read pointer
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            rdata <= '0;
        else if (rd && addr == `PIT_ADDR_CH0)
            rdata <= ch0.count_out;
        else if (rd && addr == `PIT_ADDR_CH1)
            rdata <= ch1.count_out;
    end

    // out0 resets high, so no edge is seen coming out of reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            last_out0 <= 1'b1;
            irq       <= 1'b0;
        end else begin
            last_out0 <= out0;
            irq       <= out0 & ~last_out0;
        end
    end

    assign ch0_busy = ch0.load | ch0.configure | ch0.latch_count | ch0.read_count;
    assign ch1_busy = ch1.load | ch1.configure | ch1.latch_count | ch1.read_count;

    a_one_channel: assert property (
        @(posedge clk) disable iff (reset) $onehot0({ch0_busy, ch1_busy})
    ) else $error("strobes sent to both channels in one cycle");

endmodule

`default_nettype wire

// ==== pit_top.sv ====
// ==========================================================
// two channels, irq is taken from channel 0 only
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module pit_top
    import pit_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       pit_clk,
    input  logic       cs,
    input  logic       wr_en,
    input  logic       rd_en,
    input  logic [1:0] addr,
    input  pit_byte_t  wdata,
    input  logic       gate0,
    input  logic       gate1,
    output pit_byte_t  rdata,
    output logic       out0,
    output logic       out1,
    output logic       irq
);

    pit_channel_if ch0_if ();
    pit_channel_if ch1_if ();

    pit_bus_ctrl u_bus_ctrl (
        .clk   (clk),
        .reset (reset),
        .cs    (cs),
        .wr_en (wr_en),
        .rd_en (rd_en),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .out0  (out0),
        .irq   (irq),
        .ch0   (ch0_if),
        .ch1   (ch1_if)
    );

    pit_timer_unit u_timer0 (
        .clk     (clk),
        .reset   (reset),
        .pit_clk (pit_clk),
        .gate    (gate0),
        .out     (out0),
        .bus     (ch0_if)
    );

    pit_timer_unit u_timer1 (
        .clk     (clk),
        .reset   (reset),
        .pit_clk (pit_clk),
        .gate    (gate1),
        .out     (out1),
        .bus     (ch1_if)
    );

endmodule

`default_nettype wire

// ==== tb_pit.sv ====
// ==========================================================
// reload values stay between 4 and 40 and pit_clk runs at clk/8
// ==========================================================
`timescale 1ns/1ps
`default_nettype none
`include "pit_defs.svh"

module tb_pit
    import pit_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int PIT_DIV      = 8;
    localparam int MAX_RELOAD   = 40;
    localparam int RATE_FALLS   = 4;
    localparam int SQ_CHANGES   = 4;
    // rate phase with the two extra out0 falls, square phase, and room for bus accesses
    localparam int LIMIT_CYCLES = RESET_CYCLES + (RATE_FALLS + 3) * MAX_RELOAD * PIT_DIV
                                + (SQ_CHANGES + 2) * MAX_RELOAD * PIT_DIV / 2 + 500;

    logic       clk = 1'b0;
    logic       pit_clk = 1'b0;
    logic       reset;
    logic       cs;
    logic       wr_en;
    logic       rd_en;
    logic [1:0] addr;
    pit_byte_t  wdata;
    logic       gate0;
    logic       gate1;
    pit_byte_t  rdata;
    logic       out0;
    logic       out1;
    logic       irq;

    logic       pit_run;
    logic [2:0] pit_div;
    logic       pit_clk_d;
    logic       out0_d;
    logic       out1_d;
    logic       rate_armed;
    logic       sq_on;
    logic       sq_armed;
    int         ticks0;
    int         ticks1;
    int         out0_rises;
    int         irq_pulses;
    int         reload0;
    int         reload1;
    int         value;
    int         rnd;
    integer     seed;

    pit_top u_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // pit_clk has a period of PIT_DIV clk cycles while the run flag is set
    always @(posedge clk) begin
        if (!pit_run) begin
            pit_div <= '0;
            pit_clk <= 1'b0;
        end else begin
            pit_div <= pit_div + 3'd1;
            pit_clk <= pit_div[2];
        end
    end

    // counts pit ticks between output edges from the values sampled at each edge
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            pit_clk_d  <= 1'b0;
            out0_d     <= 1'b1;
            out1_d     <= 1'b1;
            ticks0     <= 0;
            ticks1     <= 0;
            rate_armed <= 1'b0;
            sq_armed   <= 1'b0;
            out0_rises <= 0;
            irq_pulses <= 0;
        end else begin
            pit_clk_d <= pit_clk;
            out0_d    <= out0;
            out1_d    <= out1;
            if (pit_clk && !pit_clk_d) begin
                ticks0 <= ticks0 + 1;
                ticks1 <= ticks1 + 1;
            end
            // the first fall starts a full period, so checks begin after it
            if (out0_d && !out0) begin
                ticks0     <= 0;
                rate_armed <= 1'b1;
            end
            if (out1 != out1_d) begin
                ticks1   <= 0;
                sq_armed <= sq_on;
            end
            if (!out0_d && out0)
                out0_rises <= out0_rises + 1;
            if (irq)
                irq_pulses <= irq_pulses + 1;
        end
    end

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected) else report_mismatch(name, expected, actual);
    endtask

    function automatic pit_byte_t control_word(input logic [1:0] sel, input pit_rw_t rw,
                                               input pit_mode_t mode);
        pit_byte_t cw;
        cw = '0;
        cw[`PIT_CW_SEL_MSB:`PIT_CW_SEL_LSB]   = sel;
        cw[`PIT_CW_RW_MSB:`PIT_CW_RW_LSB]     = rw;
        cw[`PIT_CW_MODE_MSB:`PIT_CW_MODE_LSB] = mode;
        return cw;
    endfunction

    task automatic write_reg(input logic [1:0] a, input pit_byte_t d);
        @(posedge clk);
        cs    <= 1'b1;
        wr_en <= 1'b1;
        addr  <= a;
        wdata <= d;
        @(posedge clk);
        cs    <= 1'b0;
        wr_en <= 1'b0;
    endtask

    task automatic read_reg(input logic [1:0] a, output pit_byte_t d);
        @(posedge clk);
        cs    <= 1'b1;
        rd_en <= 1'b1;
        addr  <= a;
        @(posedge clk);
        cs    <= 1'b0;
        rd_en <= 1'b0;
        // rdata was registered at the edge that took the strobe
        @(negedge clk);
        d = rdata;
    endtask

    task automatic read_count16(input logic [1:0] a, output int v);
        pit_byte_t lo;
        pit_byte_t hi;
        read_reg(a, lo);
        read_reg(a, hi);
        v = int'({hi, lo});
    endtask

    // in the rate generator a fall of out0 marks count 1 one full period after the last
    a_rate_period: assert property (
        @(posedge clk) disable iff (reset) ($fell(out0) && rate_armed) |-> ticks0 == reload0
    ) else report_mismatch("rate_period", reload0, $sampled(ticks0));

    a_square_half: assert property (
        @(posedge clk) disable iff (reset)
            ($changed(out1) && sq_armed && sq_on) |-> ticks1 == reload1 / 2
    ) else report_mismatch("square_half_period", reload1 / 2, $sampled(ticks1));

    a_gate_forces_out: assert property (
        @(posedge clk) disable iff (reset) !gate1 |=> out1
    ) else report_mismatch("gate_low_out1", 1, int'($sampled(out1)));

    a_irq_on_rise: assert property (
        @(posedge clk) disable iff (reset) $rose(out0) |=> irq
    ) else report_mismatch("irq_after_rise", 1, int'($sampled(irq)));

    a_irq_only_on_rise: assert property (
        @(posedge clk) disable iff (reset) !$rose(out0) |=> !irq
    ) else report_mismatch("irq_single_cycle", 0, int'($sampled(irq)));

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d clock cycles", LIMIT_CYCLES);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed    = 32'h6148_dd48;
        reset   = 1'b1;
        cs      = 1'b0;
        wr_en   = 1'b0;
        rd_en   = 1'b0;
        addr    = '0;
        wdata   = '0;
        gate0   = 1'b0;
        gate1   = 1'b0;
        pit_run = 1'b0;
        sq_on   = 1'b0;
        rnd     = $random(seed);
        reload0 = 4 + (rnd & 32'h7fff_ffff) % 37;
        rnd     = $random(seed);
        reload1 = 4 + 2 * ((rnd & 32'h7fff_ffff) % 19);

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("reset_out0", 1, int'(out0));
        check_value("reset_out1", 1, int'(out1));
        check_value("reset_irq", 0, int'(irq));
        check_value("reset_rdata", 0, int'(rdata));

        // channel 0 runs as rate generator with pit_clk stopped so that gate0 loads reload - 1
        write_reg(`PIT_ADDR_CTRL, control_word(2'd0, 2'b11, 3'b010));
        write_reg(`PIT_ADDR_CH0, reload0[7:0]);
        write_reg(`PIT_ADDR_CH0, reload0[15:8]);
        @(posedge clk);
        gate0 <= 1'b1;
        repeat (2) @(posedge clk);
        write_reg(`PIT_ADDR_CTRL, control_word(2'd0, 2'b00, 3'b000));
        read_count16(`PIT_ADDR_CH0, value);
        check_value("latched_count", reload0 - 1, value);

        @(posedge clk);
        pit_run <= 1'b1;
        repeat (RATE_FALLS + 1) @(negedge out0);

        // out0 is low only while the count is 1, so a latch taken now holds 1
        @(negedge out0);
        write_reg(`PIT_ADDR_CTRL, control_word(2'd0, 2'b00, 3'b000));
        sq_on <= 1'b1;
        write_reg(`PIT_ADDR_CTRL, control_word(2'd1, 2'b11, 3'b011));
        write_reg(`PIT_ADDR_CH1, reload1[7:0]);
        write_reg(`PIT_ADDR_CH1, reload1[15:8]);
        @(posedge clk);
        gate1 <= 1'b1;
        // three pit ticks on the live count is reload - 2, so only the latch still reads 1
        repeat (2 * PIT_DIV) @(posedge clk);
        read_count16(`PIT_ADDR_CH0, value);
        check_value("latch_kept", 1, value);
        repeat (SQ_CHANGES + 1) @(out1);
        // gate1 drops while out1 is low so that the gate has to force it high
        if (out1)
            @(negedge out1);

        @(posedge clk);
        sq_on <= 1'b0;
        @(posedge clk);
        gate1 <= 1'b0;
        repeat (3 * PIT_DIV) @(posedge clk);
        @(negedge clk);
        check_value("gate_low_hold", 1, int'(out1));

        // every irq pulse has been counted here since out0 rose long ago
        @(negedge out0);
        repeat (2) @(posedge clk);
        check_value("irq_count", out0_rises, irq_pulses);

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== pit_top.f ====
+incdir+.
pit_pkg.sv
pit_channel_if.sv
pit_timer_unit.sv
pit_bus_ctrl.sv
pit_top.sv
tb_pit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs tb_pit with Verilator, sim.log holds the simulation output

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_pit -f pit_top.f -o sim_pit \
    && ./obj_dir/sim_pit > sim.log 2>&1 \
    || echo "Test failed" >> sim.log

cat sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation PASSED"
